// File: logic/alu_config_pkg.sv
////////////////////////////////////////
// Sizing and latency constants for the
// sequential arithmetic unit
////////////////////////////////////////

package alu_config_pkg;

    // Operand word size, everything else follows from it
    localparam int OPERAND_WIDTH = 8;

    // Product of two operands
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    // Bit counter inside each unit, counts 0 .. OPERAND_WIDTH-1
    localparam int STEP_COUNT_WIDTH = (OPERAND_WIDTH > 1) ? $clog2(OPERAND_WIDTH) : 1;

    // Counter value of the final step
    localparam logic [STEP_COUNT_WIDTH-1:0] LAST_STEP =
        STEP_COUNT_WIDTH'(OPERAND_WIDTH - 1);

    // Unit start pulse to unit done pulse
    // one cycle per bit plus the finishing cycle
    localparam int UNIT_LATENCY = OPERAND_WIDTH + 1;

    // Top start sampled to top done pulse
    // Adds launch cycle and result latch cycle
    localparam int ALU_LATENCY = UNIT_LATENCY + 2;

endpackage

// File: logic/alu_types_pkg.sv
////////////////////////////////////////
// Operation codes, request and result
// types of the arithmetic unit
////////////////////////////////////////

package alu_types_pkg;
    import alu_config_pkg::*;

    // Supported operations
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,  // a + b
        OP_SUB = 2'd1,  // a - b
        OP_MUL = 2'd2,  // a * b, double width
        OP_DIV = 2'd3   // a / b and a % b
    } alu_op_e;

    // Unsigned operand word
    typedef logic [OPERAND_WIDTH-1:0] operand_t;

    // One request, op plus operand pair
    typedef struct packed {
        alu_op_e  op;
        operand_t a;   // Addend, minuend, multiplicand or dividend
        operand_t b;   // Addend, subtrahend, multiplier or divisor
    } alu_request_t;

    // Result of any operation
    // high  sum, difference, quotient or product upper half
    // low   zero, remainder or product lower half
    // flag  carry, borrow or divide by zero
    typedef struct packed {
        operand_t high;
        operand_t low;
        logic     flag;
    } alu_result_t;

endpackage

// File: logic/serial_addsub.sv
////////////////////////////////////////
// Bit-serial adder and subtractor
////////////////////////////////////////
`timescale 1ns/100ps

module serial_addsub
    import alu_config_pkg::*, alu_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  logic         sub_mode,   // 0 add, 1 subtract
    input  alu_request_t operands,
    output logic         done,
    output alu_result_t  result
);
    logic                        running;
    logic [STEP_COUNT_WIDTH-1:0] step;
    logic                        sub_q;
    operand_t                    a_sh;      // Shifts right, LSB is current bit
    operand_t                    b_sh;
    operand_t                    acc;       // Result bits enter at the MSB
    logic                        chain;     // Carry or borrow from previous bit
    logic                        bit_out;
    logic                        chain_out;

    // Full adder / full subtractor cell, sum bit is the same for both
    always_comb begin
        bit_out = a_sh[0] ^ b_sh[0] ^ chain;
        if (sub_q) begin
            chain_out = (~a_sh[0] & b_sh[0]) | (~(a_sh[0] ^ b_sh[0]) & chain);
        end else begin
            chain_out = (a_sh[0] & b_sh[0]) | ((a_sh[0] ^ b_sh[0]) & chain);
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            a_sh  <= operands.a;
            b_sh  <= operands.b;
            sub_q <= sub_mode;
            chain <= 1'b0;
        end else if (running) begin
            a_sh  <= a_sh >> 1;
            b_sh  <= b_sh >> 1;
            acc   <= {bit_out, acc[OPERAND_WIDTH-1:1]};
            chain <= chain_out;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin   // MSB cell, finish here
                    running     <= 1'b0;
                    done        <= 1'b1;
                    result.high <= {bit_out, acc[OPERAND_WIDTH-1:1]};
                    result.low  <= '0;
                    result.flag <= chain_out;  // Final carry or borrow
                end
            end
        end
    end

endmodule

// File: logic/shift_add_multiplier.sv
////////////////////////////////////////
// Shift-and-add multiplier, double
// width product
////////////////////////////////////////
`timescale 1ns/100ps

module shift_add_multiplier
    import alu_config_pkg::*, alu_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  alu_request_t operands,
    output logic         done,
    output alu_result_t  result
);
    logic                        running;
    logic [STEP_COUNT_WIDTH-1:0] step;
    logic [PRODUCT_WIDTH-1:0]    mcand_sh;   // Multiplicand, moves left each step
    operand_t                    mplier_sh;  // Multiplier, LSB examined each step
    logic [PRODUCT_WIDTH-1:0]    prod;       // Partial product
    logic [PRODUCT_WIDTH-1:0]    prod_next;

    // Add shifted multiplicand when the current multiplier bit is set
    assign prod_next = mplier_sh[0] ? prod + mcand_sh : prod;

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            mcand_sh  <= {{OPERAND_WIDTH{1'b0}}, operands.a};
            mplier_sh <= operands.b;
            prod      <= '0;
        end else if (running) begin
            mcand_sh  <= mcand_sh << 1;
            mplier_sh <= mplier_sh >> 1;
            prod      <= prod_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin  // Multiplier MSB
                    running     <= 1'b0;
                    done        <= 1'b1;
                    result.high <= prod_next[PRODUCT_WIDTH-1:OPERAND_WIDTH];
                    result.low  <= prod_next[OPERAND_WIDTH-1:0];
                    result.flag <= 1'b0;      // No overflow possible
                end
            end
        end
    end

endmodule

// File: logic/restoring_divider.sv
////////////////////////////////////////
// Restoring divider with zero-divisor
// result forcing
////////////////////////////////////////
`timescale 1ns/100ps

module restoring_divider
    import alu_config_pkg::*, alu_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  alu_request_t operands,
    output logic         done,
    output alu_result_t  result
);
    logic                        running;
    logic [STEP_COUNT_WIDTH-1:0] step;
    operand_t                    divisor;
    logic                        div_zero;   // Divisor was zero at start
    operand_t                    rem;        // Partial remainder
    operand_t                    quo;        // Dividend bits out, quotient bits in
    logic [OPERAND_WIDTH:0]      shifted;    // Remainder with next dividend bit
    logic [OPERAND_WIDTH+1:0]    trial;      // Trial subtraction, MSB is borrow
    logic                        borrow;
    operand_t                    rem_next;
    operand_t                    quo_next;

    always_comb begin
        shifted  = {rem, quo[OPERAND_WIDTH-1]};
        trial    = {1'b0, shifted} - {2'b00, divisor};
        borrow   = trial[OPERAND_WIDTH+1];
        // Restore on borrow, keep difference otherwise
        rem_next = borrow ? shifted[OPERAND_WIDTH-1:0] : trial[OPERAND_WIDTH-1:0];
        quo_next = {quo[OPERAND_WIDTH-2:0], ~borrow};
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start) begin
            divisor  <= operands.b;
            div_zero <= (operands.b == '0);
            rem      <= '0;
            quo      <= operands.a;
        end else if (running) begin
            rem <= rem_next;
            quo <= quo_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            step    <= '0;
            done    <= 1'b0;
            result  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                step <= step + 1'b1;
                if (step == LAST_STEP) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                    // Zero divisor runs the full count, then forces the result
                    if (div_zero) begin
                        result.high <= '0;
                        result.low  <= '0;
                        result.flag <= 1'b1;
                    end else begin
                        result.high <= quo_next;
                        result.low  <= rem_next;
                        result.flag <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

// File: logic/op_sequencer.sv
////////////////////////////////////////
// Request capture, unit launch, result
// latch and done pulse
////////////////////////////////////////
`timescale 1ns/100ps

module op_sequencer
    import alu_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,
    input  alu_request_t req,
    output logic         addsub_start,
    output logic         sub_mode,       // Level, valid with addsub_start
    output logic         mul_start,
    output logic         div_start,
    output alu_request_t operands,       // Captured request, held until next capture
    input  logic         addsub_done,
    input  logic         mul_done,
    input  logic         div_done,
    input  alu_result_t  addsub_result,
    input  alu_result_t  mul_result,
    input  alu_result_t  div_result,
    output logic         busy,
    output logic         done,
    output alu_result_t  result
);
    typedef enum logic [1:0] {
        S_IDLE,    // Waiting for a request
        S_RUN,     // Unit launched, waiting for its done
        S_FINISH   // Done pulse cycle
    } seq_state_e;

    seq_state_e   state;
    alu_request_t req_q;
    logic         launch;      // One cycle after capture
    logic         accept;
    logic         sel_done;
    alu_result_t  sel_result;

    assign accept   = start && !busy;   // Starts while busy are dropped
    assign operands = req_q;
    assign sub_mode = (req_q.op == OP_SUB);

    // Only the launched unit is watched
    always_comb begin
        case (req_q.op)
            OP_MUL: begin
                sel_done   = mul_done;
                sel_result = mul_result;
            end
            OP_DIV: begin
                sel_done   = div_done;
                sel_result = div_result;
            end
            default: begin     // Add and subtract share one unit
                sel_done   = addsub_done;
                sel_result = addsub_result;
            end
        endcase
    end

    // Request register
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= S_IDLE;
            busy         <= 1'b0;
            done         <= 1'b0;
            launch       <= 1'b0;
            addsub_start <= 1'b0;
            mul_start    <= 1'b0;
            div_start    <= 1'b0;
            result       <= '0;
        end else begin
            // Pulses by default
            done         <= 1'b0;
            launch       <= 1'b0;
            addsub_start <= launch && (req_q.op == OP_ADD || req_q.op == OP_SUB);
            mul_start    <= launch && (req_q.op == OP_MUL);
            div_start    <= launch && (req_q.op == OP_DIV);

            case (state)
                S_IDLE, S_FINISH: begin
                    if (accept) begin   // busy is low here
                        busy   <= 1'b1;
                        launch <= 1'b1;
                        state  <= S_RUN;
                    end else begin
                        state  <= S_IDLE;
                    end
                end
                S_RUN: begin
                    if (sel_done) begin
                        result <= sel_result;  // Held until next completion
                        done   <= 1'b1;
                        busy   <= 1'b0;
                        state  <= S_FINISH;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// File: logic/seq_alu.sv
////////////////////////////////////////
// Top level, sequencer plus add/sub,
// multiply and divide units
////////////////////////////////////////
`timescale 1ns/100ps

module seq_alu
    import alu_types_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         start,   // Request strobe
    input  alu_request_t req,
    output logic         busy,    // High while an op is in flight
    output logic         done,    // One-cycle completion pulse
    output alu_result_t  result   // Valid from done until next done
);
    // Unit launch
    logic         addsub_start;
    logic         sub_mode;
    logic         mul_start;
    logic         div_start;
    alu_request_t operands;

    // Unit completion
    logic         addsub_done;
    logic         mul_done;
    logic         div_done;
    alu_result_t  addsub_result;
    alu_result_t  mul_result;
    alu_result_t  div_result;

    op_sequencer u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .req           (req),
        .addsub_start  (addsub_start),
        .sub_mode      (sub_mode),
        .mul_start     (mul_start),
        .div_start     (div_start),
        .operands      (operands),
        .addsub_done   (addsub_done),
        .mul_done      (mul_done),
        .div_done      (div_done),
        .addsub_result (addsub_result),
        .mul_result    (mul_result),
        .div_result    (div_result),
        .busy          (busy),
        .done          (done),
        .result        (result)
    );

    serial_addsub u_addsub (
        .clk      (clk),
        .reset    (reset),
        .start    (addsub_start),
        .sub_mode (sub_mode),
        .operands (operands),
        .done     (addsub_done),
        .result   (addsub_result)
    );

    shift_add_multiplier u_mul (
        .clk      (clk),
        .reset    (reset),
        .start    (mul_start),
        .operands (operands),
        .done     (mul_done),
        .result   (mul_result)
    );

    restoring_divider u_div (
        .clk      (clk),
        .reset    (reset),
        .start    (div_start),
        .operands (operands),
        .done     (div_done),
        .result   (div_result)
    );

endmodule

// File: testbench/seq_alu_tb.sv
////////////////////////////////////////
// Testbench for seq_alu, xorshift stimulus,
// reference model and assertions
////////////////////////////////////////
`timescale 1ns/100ps

module seq_alu_tb
    import alu_config_pkg::*, alu_types_pkg::*;
();
    localparam int WAIT_LIMIT = 4 * ALU_LATENCY;   // Cycles before a wait gives up
    localparam int RANDOM_OPS = 16;
    localparam operand_t ALL_ONES = '1;
    localparam operand_t ONE      = operand_t'(1);
    localparam operand_t TOP_BIT  = {1'b1, {(OPERAND_WIDTH-1){1'b0}}};

    logic         clk;
    logic         reset;
    logic         start;
    alu_request_t req;
    logic         busy;
    logic         done;
    alu_result_t  result;

    int          error_count;
    int          tests_passed;
    int          tests_failed;
    int          test_errors;   // error_count when the current test began
    logic [31:0] rng_state;

    seq_alu dut0 (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .req    (req),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #10 clk = ~clk;   // 20 ns period

    // done is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else begin
            $display("error at %0t ns: done expected 0 got 1 one cycle after done", $time);
            error_count++;
        end

    // busy drops on the same edge that raises done
    assert property (@(posedge clk) disable iff (reset) !(done && busy))
        else begin
            $display("busy and done were high together at %0t ns", $time);
            error_count++;
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic operand_t random_operand();
        rng_state = xorshift32(rng_state);
        return rng_state[OPERAND_WIDTH-1:0];
    endfunction

    function automatic alu_request_t make_request(input alu_op_e op, input operand_t a,
                                                  input operand_t b);
        alu_request_t r;
        r.op = op;
        r.a  = a;
        r.b  = b;
        return r;
    endfunction

    // Expected result straight from the arithmetic rules
    function automatic alu_result_t expected_result(input alu_request_t r);
        alu_result_t                e;
        logic [OPERAND_WIDTH:0]     wide;
        logic [2*OPERAND_WIDTH-1:0] prod;
        e = '0;
        case (r.op)
            OP_ADD: begin
                wide   = {1'b0, r.a} + {1'b0, r.b};
                e.high = wide[OPERAND_WIDTH-1:0];
                e.flag = wide[OPERAND_WIDTH];     // Carry out
            end
            OP_SUB: begin
                e.high = r.a - r.b;               // Wraps modulo 2**OPERAND_WIDTH
                e.flag = (r.a < r.b);             // Borrow
            end
            OP_MUL: begin
                prod = {{OPERAND_WIDTH{1'b0}}, r.a} * {{OPERAND_WIDTH{1'b0}}, r.b};
                {e.high, e.low} = prod;
            end
            default: begin
                if (r.b == '0) begin
                    e.flag = 1'b1;                // Divide by zero leaves high and low at 0
                end else begin
                    e.high = r.a / r.b;
                    e.low  = r.a % r.b;
                end
            end
        endcase
        return e;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
            else begin
                $display("error at %0t ns: %s expected %0h got %0h", $time, name,
                         expected, actual);
                error_count++;
            end
    endtask

    // One request plus an optional stray start poke_at cycles in
    // Checks busy, latency and result
    task automatic run_op(input alu_request_t r, input int poke_at);
        alu_result_t  want;
        alu_request_t junk;
        int           cycles;
        bit           seen;
        want   = expected_result(r);
        junk   = make_request(OP_MUL, random_operand(), random_operand());
        cycles = 0;
        seen   = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        req   <= r;
        @(posedge clk);                            // Start sampled on this edge
        start <= 1'b0;
        @(negedge clk);
        check_value("busy", 1, int'(busy));        // Raised by the sampling edge
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (cycles == poke_at) begin           // Ignored since busy is high
                start <= 1'b1;
                req   <= junk;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            cycles++;
            if (done) begin
                seen = 1'b1;
            end else begin
                check_value("busy", 1, int'(busy));
            end
        end
        if (!seen) begin
            $display("timeout: done did not arrive within %0d cycles of start at %0t ns",
                     WAIT_LIMIT, $time);
            error_count++;
        end else begin
            check_value("done latency", ALU_LATENCY, cycles);
            check_value("busy", 0, int'(busy));
            check_value("result.high", int'(want.high), int'(result.high));
            check_value("result.low", int'(want.low), int'(result.low));
            check_value("result.flag", int'(want.flag), int'(result.flag));
        end
    endtask

    // Nothing pending so neither done nor busy
    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_value("done", 0, int'(done));
            check_value("busy", 0, int'(busy));
        end
    endtask

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
        end
    endtask

    initial begin
        operand_t divisor;
        clk          = 1'b0;
        reset        = 1'b1;
        start        = 1'b0;
        req          = '0;
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_errors  = 0;
        rng_state    = 32'hc023;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Everything cleared before the first start
        start_test();
        @(negedge clk);
        check_value("busy", 0, int'(busy));
        check_value("done", 0, int'(done));
        check_value("result.high", 0, int'(result.high));
        check_value("result.low", 0, int'(result.low));
        check_value("result.flag", 0, int'(result.flag));
        finish_test("reset");

        start_test();
        run_op(make_request(OP_ADD, '0, '0), -1);
        run_op(make_request(OP_ADD, ALL_ONES, ONE), -1);          // Wraps to zero
        run_op(make_request(OP_ADD, ALL_ONES, ALL_ONES), -1);
        run_op(make_request(OP_ADD, TOP_BIT, TOP_BIT), -1);
        run_op(make_request(OP_SUB, '0, ONE), -1);                // Borrow
        run_op(make_request(OP_SUB, ONE, ONE), -1);
        run_op(make_request(OP_SUB, ALL_ONES, '0), -1);
        run_op(make_request(OP_SUB, '0, ALL_ONES), -1);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            run_op(make_request(OP_ADD, random_operand(), random_operand()), -1);
            run_op(make_request(OP_SUB, random_operand(), random_operand()), -1);
        end
        finish_test("add and subtract");

        start_test();
        run_op(make_request(OP_MUL, ALL_ONES, ALL_ONES), -1);     // Largest product
        run_op(make_request(OP_MUL, '0, random_operand()), -1);
        for (int i = 0; i < RANDOM_OPS; i++) begin
            run_op(make_request(OP_MUL, random_operand(), random_operand()), -1);
        end
        finish_test("multiply");

        start_test();
        for (int i = 0; i < RANDOM_OPS; i++) begin
            divisor = random_operand() >> (i % OPERAND_WIDTH);   // Mix of small divisors
            if (divisor == '0) begin
                divisor = ONE;
            end
            run_op(make_request(OP_DIV, random_operand(), divisor), -1);
        end
        run_op(make_request(OP_DIV, '0, '0), -1);
        for (int i = 0; i < 4; i++) begin
            run_op(make_request(OP_DIV, random_operand(), '0), -1);
        end
        finish_test("divide");

        // One op per unit through the latency and busy checks
        start_test();
        run_op(make_request(OP_ADD, random_operand(), random_operand()), -1);
        run_op(make_request(OP_SUB, random_operand(), random_operand()), -1);
        run_op(make_request(OP_MUL, random_operand(), random_operand()), -1);
        run_op(make_request(OP_DIV, random_operand(), '0), -1);
        finish_test("latency and busy");

        start_test();
        run_op(make_request(OP_ADD, random_operand(), random_operand()), 4);
        expect_quiet(ALU_LATENCY);                                // No second done
        run_op(make_request(OP_DIV, random_operand(), ONE + ONE), 2);
        run_op(make_request(OP_SUB, random_operand(), random_operand()), -1);  // Back to back
        run_op(make_request(OP_MUL, random_operand(), random_operand()), -1);
        finish_test("start while busy");

        $display("tests passed %0d, failed %0d, check errors %0d", tests_passed,
                 tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/alu_config_pkg.sv
logic/alu_types_pkg.sv
logic/serial_addsub.sv
logic/shift_add_multiplier.sv
logic/restoring_divider.sv
logic/op_sequencer.sv
logic/seq_alu.sv
testbench/seq_alu_tb.sv

// File: Makefile
# Verilator build and run for the sequential arithmetic unit

TOP     := seq_alu_tb
OBJ_DIR := obj_dir
LOG     := sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/100ps -f filelist.f \
		--top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps -f filelist.f \
		--top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
